//--- Makefile
# Verilator build and run for the PPU system testbench

.PHONY: all run lint clean

all: run

obj_dir/Vtb_ppu_system: filelist.f $(wildcard src/*.sv) $(wildcard tests/*.sv)
	verilator --binary --timing -j 0 --top-module tb_ppu_system -f filelist.f

# the log decides pass or fail
run: obj_dir/Vtb_ppu_system
	./obj_dir/Vtb_ppu_system > sim.log 2>&1; cat sim.log
	grep -q "All tests passed" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module tb_ppu_system -f filelist.f

clean:
	rm -rf obj_dir sim.log

//--- filelist.f
src/ppu_pkg.sv
src/ppu_timing.sv
src/ppu_registers.sv
src/ppu_vram_port.sv
src/ppu_palette.sv
src/ppu.sv
src/vram.sv
src/ppu_system.sv
tests/tb_ppu_system.sv

//--- src/ppu.sv
// picture processing unit (2C02)
// register file, pixel clock, VRAM port and palette
`timescale 1ns/1ps
`default_nettype none

module ppu (
    input  logic              i_clk,
    input  logic              i_reset_n,
    input  logic              i_cs_n,
    input  ppu_pkg::ppu_rw_e  i_rw,
    input  ppu_pkg::ppu_reg_e i_rs,
    input  logic [7:0]        i_data,
    output logic [7:0]        o_data,
    output logic              o_int_n,
    output logic              o_vram_rd_n,
    output logic              o_vram_we_n,
    output logic [13:0]       o_vram_address,
    output logic [7:0]        o_vram_data,
    input  logic [7:0]        i_vram_data,
    output logic [7:0]        o_video_red,
    output logic [7:0]        o_video_green,
    output logic [7:0]        o_video_blue,
    output logic [8:0]        o_video_x,
    output logic [8:0]        o_video_y,
    output logic              o_video_visible
);

    logic        w_vblank_start;
    logic        w_vblank_end;
    logic        w_vram_start_rd;
    logic        w_vram_start_wr;
    logic [13:0] w_vram_addr;
    logic [7:0]  w_vram_wdata;
    logic [7:0]  w_buffer;
    logic        w_pal_we;
    logic [4:0]  w_pal_addr;
    logic [5:0]  w_pal_wdata;
    logic [4:0]  w_pal_rd_addr;
    logic [5:0]  w_pal_rdata;

    ppu_timing timing_i (
        .i_clk(i_clk),
        .i_reset_n(i_reset_n),
        .o_x(o_video_x),
        .o_y(o_video_y),
        .o_visible(o_video_visible),
        .o_vblank_start(w_vblank_start),
        .o_vblank_end(w_vblank_end)
    );

    ppu_registers registers_i (
        .i_clk(i_clk),
        .i_reset_n(i_reset_n),
        .i_cs_n(i_cs_n),
        .i_rw(i_rw),
        .i_rs(i_rs),
        .i_data(i_data),
        .o_data(o_data),
        .i_vblank_start(w_vblank_start),
        .i_vblank_end(w_vblank_end),
        .o_int_n(o_int_n),
        .o_vram_start_rd(w_vram_start_rd),
        .o_vram_start_wr(w_vram_start_wr),
        .o_vram_addr(w_vram_addr),
        .o_vram_wdata(w_vram_wdata),
        .o_pal_we(w_pal_we),
        .o_pal_addr(w_pal_addr),
        .o_pal_wdata(w_pal_wdata),
        .o_pal_rd_addr(w_pal_rd_addr),
        .i_buffer(w_buffer),
        .i_pal_rdata(w_pal_rdata)
    );

    ppu_vram_port vram_port_i (
        .i_clk(i_clk),
        .i_reset_n(i_reset_n),
        .i_start_rd(w_vram_start_rd),
        .i_start_wr(w_vram_start_wr),
        .i_addr(w_vram_addr),
        .i_wdata(w_vram_wdata),
        .o_buffer(w_buffer),
        .o_vram_rd_n(o_vram_rd_n),
        .o_vram_we_n(o_vram_we_n),
        .o_vram_address(o_vram_address),
        .o_vram_data(o_vram_data),
        .i_vram_data(i_vram_data)
    );

    ppu_palette palette_i (
        .i_clk(i_clk),
        .i_reset_n(i_reset_n),
        .i_we(w_pal_we),
        .i_addr(w_pal_addr),
        .i_wdata(w_pal_wdata),
        .i_rd_addr(w_pal_rd_addr),
        .o_rdata(w_pal_rdata),
        .o_red(o_video_red),
        .o_green(o_video_green),
        .o_blue(o_video_blue)
    );

endmodule

`default_nettype wire

//--- src/ppu_palette.sv
// PPU palette RAM
// 32 colour entries with backdrop mirroring and the registered RGB lookup
`timescale 1ns/1ps
`default_nettype none

module ppu_palette (
    input  logic       i_clk,
    input  logic       i_reset_n,
    input  logic       i_we,
    input  logic [4:0] i_addr,
    input  logic [5:0] i_wdata,
    input  logic [4:0] i_rd_addr,
    output logic [5:0] o_rdata,
    output logic [7:0] o_red,
    output logic [7:0] o_green,
    output logic [7:0] o_blue
);
    import ppu_pkg::*;

    logic [5:0]  r_pal [32];
    logic [23:0] r_rgb;

    // entries 10, 14, 18 and 1C alias the background ones
    function automatic logic [4:0] fold_addr(input logic [4:0] addr);
        if (addr[1:0] == 2'b00)
        begin
            return {1'b0, addr[3:0]};
        end
        return addr;
    endfunction

    always_ff @(posedge i_clk)
    begin
        if (i_we)
        begin
            r_pal[fold_addr(i_addr)] <= i_wdata;
        end
    end

    assign o_rdata = r_pal[fold_addr(i_rd_addr)];

    // backdrop colour only, no pixel pipeline yet
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            r_rgb <= 24'h000000;
        end
        else
        begin
            r_rgb <= MASTER_RGB[r_pal[0]];
        end
    end

    assign o_red = r_rgb[23:16];
    assign o_green = r_rgb[15:8];
    assign o_blue = r_rgb[7:0];

endmodule

`default_nettype wire

//--- src/ppu_pkg.sv
// PPU shared definitions
// screen geometry, CPU register selects and the 2C02 master colour table
`default_nettype none

package ppu_pkg;

    // dot and line geometry of one NTSC frame
    localparam logic [8:0] SCREEN_WIDTH = 9'd341;
    localparam logic [8:0] SCREEN_HEIGHT = 9'd262;
    localparam logic [8:0] SCREEN_VISIBLE_WIDTH = 9'd256;
    localparam logic [8:0] SCREEN_VISIBLE_HEIGHT = 9'd240;
    localparam logic [8:0] VBLANK_START_LINE = 9'd241;

    // start of the palette window in PPU address space
    localparam logic [15:0] PALETTE_BASE = 16'h3F00;

    // register select, in the chip's order
    typedef enum logic [2:0] {
        RS_PPUCTRL = 3'd0,
        RS_PPUMASK = 3'd1,
        RS_PPUSTATUS = 3'd2,
        RS_OAMADDR = 3'd3,
        RS_OAMDATA = 3'd4,
        RS_PPUSCROLL = 3'd5,
        RS_PPUADDR = 3'd6,
        RS_PPUDATA = 3'd7
    } ppu_reg_e;

    // CPU bus direction
    typedef enum logic {
        RW_WRITE = 1'b0,
        RW_READ = 1'b1
    } ppu_rw_e;

    // master palette as 8/8/8 RGB, indexed by the 6-bit colour number
    localparam logic [23:0] MASTER_RGB [64] = '{
        24'h666666, 24'h002A88, 24'h1412A7, 24'h3B00A4,
        24'h5C007E, 24'h6E0040, 24'h6C0600, 24'h561D00,
        24'h333500, 24'h0B4800, 24'h005200, 24'h004F08,
        24'h00404D, 24'h000000, 24'h000000, 24'h000000,
        24'hADADAD, 24'h155FD9, 24'h4240FF, 24'h7527FE,
        24'hA01ACC, 24'hB71E7B, 24'hB53120, 24'h994E00,
        24'h6B6D00, 24'h388700, 24'h0C9300, 24'h008F32,
        24'h007C8D, 24'h000000, 24'h000000, 24'h000000,
        24'hFFFEFF, 24'h64B0FF, 24'h9290FF, 24'hC676FF,
        24'hF36AFF, 24'hFE6ECC, 24'hFE8170, 24'hEA9E22,
        24'hBCBE00, 24'h88D800, 24'h5CE430, 24'h45E082,
        24'h48CDDE, 24'h4F4F4F, 24'h000000, 24'h000000,
        24'hFFFEFF, 24'hC0DFFF, 24'hD3D2FF, 24'hE8C8FF,
        24'hFBC2FF, 24'hFEC4EA, 24'hFECCC5, 24'hF7D8A5,
        24'hE4E594, 24'hCFEF96, 24'hBDF4AB, 24'hB3F3CC,
        24'hB5EBF2, 24'hB8B8B8, 24'h000000, 24'h000000
    };

endpackage

`default_nettype wire

//--- src/ppu_registers.sv
// PPU CPU register file
// decodes bus accesses into control, scroll, OAM, NMI and PPUDATA requests
`timescale 1ns/1ps
`default_nettype none

module ppu_registers (
    input  logic              i_clk,
    input  logic              i_reset_n,
    input  logic              i_cs_n,
    input  ppu_pkg::ppu_rw_e  i_rw,
    input  ppu_pkg::ppu_reg_e i_rs,
    input  logic [7:0]        i_data,
    output logic [7:0]        o_data,
    input  logic              i_vblank_start,
    input  logic              i_vblank_end,
    output logic              o_int_n,
    output logic              o_vram_start_rd,
    output logic              o_vram_start_wr,
    output logic [13:0]       o_vram_addr,
    output logic [7:0]        o_vram_wdata,
    output logic              o_pal_we,
    output logic [4:0]        o_pal_addr,
    output logic [5:0]        o_pal_wdata,
    output logic [4:0]        o_pal_rd_addr,
    input  logic [7:0]        i_buffer,
    input  logic [5:0]        i_pal_rdata
);
    import ppu_pkg::*;

    logic [7:0]  r_ppuctrl;
    logic [7:0]  r_oamaddr;
    logic [7:0]  r_oam [256];
    logic [14:0] r_v;
    logic [14:0] r_t;
    logic        r_w;
    logic        r_vblank;

    logic w_acc_wr;
    logic w_acc_rd;
    logic w_status_rd;
    logic w_data_acc;
    logic w_in_palette;

    assign w_acc_wr = !i_cs_n && (i_rw == RW_WRITE);
    assign w_acc_rd = !i_cs_n && (i_rw == RW_READ);
    assign w_status_rd = w_acc_rd && (i_rs == RS_PPUSTATUS);
    assign w_data_acc = !i_cs_n && (i_rs == RS_PPUDATA);
    // v doubles as the PPUADDR pointer, as on the chip
    assign w_in_palette = {2'b00, r_v[13:0]} >= PALETTE_BASE;

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            r_ppuctrl <= 8'h00;
            r_oamaddr <= 8'h00;
            r_v <= 15'd0;
            r_t <= 15'd0;
            r_w <= 1'b0;
            r_vblank <= 1'b0;
        end
        else
        begin
            // status read wins over a vblank edge in the same cycle
            if (w_status_rd)
            begin
                r_vblank <= 1'b0;
                r_w <= 1'b0;
            end
            else if (i_vblank_start)
            begin
                r_vblank <= 1'b1;
            end
            else if (i_vblank_end)
            begin
                r_vblank <= 1'b0;
            end

            if (w_acc_wr)
            begin
                case (i_rs)
                    RS_PPUCTRL:
                    begin
                        r_ppuctrl <= i_data;
                        r_t[11:10] <= i_data[1:0];
                    end
                    RS_OAMADDR: r_oamaddr <= i_data;
                    RS_OAMDATA: r_oamaddr <= r_oamaddr + 8'd1;
                    RS_PPUSCROLL:
                    begin
                        // first write is x, second is y
                        if (!r_w)
                        begin
                            r_t[4:0] <= i_data[7:3];
                        end
                        else
                        begin
                            r_t[9:5] <= i_data[7:3];
                            r_t[14:12] <= i_data[2:0];
                        end
                        r_w <= !r_w;
                    end
                    RS_PPUADDR:
                    begin
                        // high byte first, v follows t on the low byte
                        if (!r_w)
                        begin
                            r_t[13:8] <= i_data[5:0];
                            r_t[14] <= 1'b0;
                        end
                        else
                        begin
                            r_t[7:0] <= i_data;
                            r_v <= {r_t[14:8], i_data};
                        end
                        r_w <= !r_w;
                    end
                    default:
                    begin
                    end
                endcase
            end

            if (w_data_acc)
            begin
                r_v <= r_v + (r_ppuctrl[2] ? 15'd32 : 15'd1);
            end
        end
    end

    // sprite memory
    always_ff @(posedge i_clk)
    begin
        if (w_acc_wr && (i_rs == RS_OAMDATA))
        begin
            r_oam[r_oamaddr] <= i_data;
        end
    end

    always_comb
    begin
        o_data = 8'h00;
        if (w_acc_rd)
        begin
            case (i_rs)
                RS_PPUSTATUS: o_data = {r_vblank, 7'b000_0000};
                RS_OAMDATA: o_data = r_oam[r_oamaddr];
                RS_PPUDATA: o_data = w_in_palette ? {2'b00, i_pal_rdata} : i_buffer;
                default: o_data = 8'h00;
            endcase
        end
    end

    assign o_int_n = !(r_vblank && r_ppuctrl[7]);

    // PPUDATA goes to the palette above 3F00 and to VRAM below it
    assign o_vram_start_rd = w_data_acc && (i_rw == RW_READ) && !w_in_palette;
    assign o_vram_start_wr = w_data_acc && w_acc_wr && !w_in_palette;
    assign o_vram_addr = r_v[13:0];
    assign o_vram_wdata = i_data;

    assign o_pal_we = w_data_acc && w_acc_wr && w_in_palette;
    assign o_pal_addr = r_v[4:0];
    assign o_pal_wdata = i_data[5:0];
    assign o_pal_rd_addr = r_v[4:0];

endmodule

`default_nettype wire

//--- src/ppu_system.sv
// PPU system
// the 2C02 with its video RAM on the VRAM bus
`timescale 1ns/1ps
`default_nettype none

module ppu_system (
    input  logic              i_clk,
    input  logic              i_reset_n,
    input  logic              i_cs_n,
    input  ppu_pkg::ppu_rw_e  i_rw,
    input  ppu_pkg::ppu_reg_e i_rs,
    input  logic [7:0]        i_data,
    output logic [7:0]        o_data,
    output logic              o_int_n,
    output logic [7:0]        o_video_red,
    output logic [7:0]        o_video_green,
    output logic [7:0]        o_video_blue,
    output logic [8:0]        o_video_x,
    output logic [8:0]        o_video_y,
    output logic              o_video_visible
);

    logic        w_vram_rd_n;
    logic        w_vram_we_n;
    logic [13:0] w_vram_address;
    logic [7:0]  w_vram_wdata;
    logic [7:0]  w_vram_rdata;

    ppu ppu_i (
        .i_clk(i_clk),
        .i_reset_n(i_reset_n),
        .i_cs_n(i_cs_n),
        .i_rw(i_rw),
        .i_rs(i_rs),
        .i_data(i_data),
        .o_data(o_data),
        .o_int_n(o_int_n),
        .o_vram_rd_n(w_vram_rd_n),
        .o_vram_we_n(w_vram_we_n),
        .o_vram_address(w_vram_address),
        .o_vram_data(w_vram_wdata),
        .i_vram_data(w_vram_rdata),
        .o_video_red(o_video_red),
        .o_video_green(o_video_green),
        .o_video_blue(o_video_blue),
        .o_video_x(o_video_x),
        .o_video_y(o_video_y),
        .o_video_visible(o_video_visible)
    );

    vram vram_i (
        .i_clk(i_clk),
        .i_rd_n(w_vram_rd_n),
        .i_we_n(w_vram_we_n),
        .i_address(w_vram_address),
        .i_data(w_vram_wdata),
        .o_data(w_vram_rdata)
    );

endmodule

`default_nettype wire

//--- src/ppu_timing.sv
// PPU pixel clock
// walks dots and scanlines and flags the visible area and vblank edges
`timescale 1ns/1ps
`default_nettype none

module ppu_timing (
    input  logic       i_clk,
    input  logic       i_reset_n,
    output logic [8:0] o_x,
    output logic [8:0] o_y,
    output logic       o_visible,
    output logic       o_vblank_start,
    output logic       o_vblank_end
);
    import ppu_pkg::*;

    logic [8:0] r_x;
    logic [8:0] r_y;

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            r_x <= 9'd0;
            r_y <= 9'd0;
        end
        else if (r_x != SCREEN_WIDTH - 9'd1)
        begin
            r_x <= r_x + 9'd1;
        end
        else
        begin
            r_x <= 9'd0;
            // last line of the frame wraps back to the top
            r_y <= (r_y == SCREEN_HEIGHT - 9'd1) ? 9'd0 : r_y + 9'd1;
        end
    end

    assign o_x = r_x;
    assign o_y = r_y;
    assign o_visible = (r_x < SCREEN_VISIBLE_WIDTH) && (r_y < SCREEN_VISIBLE_HEIGHT);

    // single-dot pulses at the first dot of the vblank lines
    assign o_vblank_start = (r_x == 9'd0) && (r_y == VBLANK_START_LINE);
    assign o_vblank_end = (r_x == 9'd0) && (r_y == SCREEN_HEIGHT - 9'd1);

endmodule

`default_nettype wire

//--- src/ppu_vram_port.sv
// PPU VRAM port
// turns PPUDATA requests into one strobe cycle and keeps the read buffer
`timescale 1ns/1ps
`default_nettype none

module ppu_vram_port (
    input  logic        i_clk,
    input  logic        i_reset_n,
    input  logic        i_start_rd,
    input  logic        i_start_wr,
    input  logic [13:0] i_addr,
    input  logic [7:0]  i_wdata,
    output logic [7:0]  o_buffer,
    output logic        o_vram_rd_n,
    output logic        o_vram_we_n,
    output logic [13:0] o_vram_address,
    output logic [7:0]  o_vram_data,
    input  logic [7:0]  i_vram_data
);

    logic        r_rd_n;
    logic        r_we_n;
    logic [13:0] r_address;
    logic [7:0]  r_buffer;

    // cycle 1 accepts the request, cycle 2 drives the strobe
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            r_rd_n <= 1'b1;
            r_we_n <= 1'b1;
            r_address <= 14'd0;
            r_buffer <= 8'h00;
        end
        else
        begin
            // strobes last exactly one cycle
            r_rd_n <= !i_start_rd;
            r_we_n <= !i_start_wr;

            if (i_start_rd || i_start_wr)
            begin
                r_address <= i_addr;
            end

            // a write parks its byte in the buffer, which also feeds the bus
            if (i_start_wr)
            begin
                r_buffer <= i_wdata;
            end
            else if (!r_rd_n)
            begin
                r_buffer <= i_vram_data;
            end
        end
    end

    assign o_buffer = r_buffer;
    assign o_vram_rd_n = r_rd_n;
    assign o_vram_we_n = r_we_n;
    assign o_vram_address = r_address;
    assign o_vram_data = !r_we_n ? r_buffer : 8'h00;

endmodule

`default_nettype wire

//--- src/vram.sv
// video RAM
// 16 KiB of bytes, written on the clock edge and read asynchronously
`timescale 1ns/1ps
`default_nettype none

module vram (
    input  logic        i_clk,
    input  logic        i_rd_n,
    input  logic        i_we_n,
    input  logic [13:0] i_address,
    input  logic [7:0]  i_data,
    output logic [7:0]  o_data
);

    logic [7:0] r_mem [16384];

    always_ff @(posedge i_clk)
    begin
        if (!i_we_n)
        begin
            r_mem[i_address] <= i_data;
        end
    end

    // bus idles at zero when not selected for read
    assign o_data = !i_rd_n ? r_mem[i_address] : 8'h00;

endmodule

`default_nettype wire

//--- tests/tb_ppu_system.sv
// testbench for the PPU system
// directed register-bus tests for VRAM, palette, OAM, vblank and the scroll toggle
`timescale 1ns/1ps
`default_nettype none

module tb_ppu_system;
    import ppu_pkg::*;

    // two frames of dots plus headroom for the bus traffic
    localparam int TIMEOUT_CYCLES = 200000;
    localparam int IDLE_CYCLES = 3;

    logic       clk;
    logic       reset_n;
    logic       cs_n;
    ppu_rw_e    rw;
    ppu_reg_e   rs;
    logic [7:0] wdata;
    logic [7:0] rdata;
    logic       int_n;
    logic [7:0] video_red;
    logic [7:0] video_green;
    logic [7:0] video_blue;
    logic [8:0] video_x;
    logic [8:0] video_y;
    logic       video_visible;

    int cycles;
    int errors;
    int errors_before;
    int tests_run;
    int tests_failed;

    ppu_system dut_i (
        .i_clk(clk),
        .i_reset_n(reset_n),
        .i_cs_n(cs_n),
        .i_rw(rw),
        .i_rs(rs),
        .i_data(wdata),
        .o_data(rdata),
        .o_int_n(int_n),
        .o_video_red(video_red),
        .o_video_green(video_green),
        .o_video_blue(video_blue),
        .o_video_x(video_x),
        .o_video_y(video_y),
        .o_video_visible(video_visible)
    );

    always #50 clk = ~clk;

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles, the DUT never reached the awaited state", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    // one access cycle, then the idle gap the VRAM port needs
    task automatic bus_write(input ppu_reg_e sel, input logic [7:0] value);
        @(posedge clk);
        cs_n <= 1'b0;
        rw <= RW_WRITE;
        rs <= sel;
        wdata <= value;
        @(posedge clk);
        cs_n <= 1'b1;
        repeat (IDLE_CYCLES) @(posedge clk);
    endtask

    task automatic bus_read(input ppu_reg_e sel, output logic [7:0] value);
        @(posedge clk);
        cs_n <= 1'b0;
        rw <= RW_READ;
        rs <= sel;
        // read data is combinational, so take it mid-cycle
        @(negedge clk);
        value = rdata;
        @(posedge clk);
        cs_n <= 1'b1;
        repeat (IDLE_CYCLES) @(posedge clk);
    endtask

    task automatic expect_read(input ppu_reg_e sel, input logic [7:0] exp, input string what);
        logic [7:0] got;
        bus_read(sel, got);
        if (got !== exp)
        begin
            $display("Mismatch at %0d ns: %s = %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic set_addr(input logic [7:0] hi, input logic [7:0] lo);
        bus_write(RS_PPUADDR, hi);
        bus_write(RS_PPUADDR, lo);
    endtask

    task automatic expect_int_n(input logic exp);
        if (int_n !== exp)
        begin
            $display("Mismatch at %0d ns: o_int_n = %b, expected %b", $time, int_n, exp);
            errors++;
        end
    endtask

    task automatic close_test(input string name);
        tests_run++;
        if (errors == errors_before)
        begin
            $display("%s: ok", name);
        end
        else
        begin
            tests_failed++;
            $display("%s: %0d errors", name, errors - errors_before);
        end
        errors_before = errors;
    endtask

    task automatic test_reset_state;
        // first cycle with reset released
        @(negedge clk);
        if (video_x !== 9'd0 || video_y !== 9'd0)
        begin
            $display("Mismatch at %0d ns: o_video_x/o_video_y = %0d/%0d, expected 0/0",
                     $time, video_x, video_y);
            errors++;
        end
        if (video_visible !== 1'b1)
        begin
            $display("Mismatch at %0d ns: o_video_visible = %b, expected 1",
                     $time, video_visible);
            errors++;
        end
        if (rdata !== 8'h00)
        begin
            $display("Mismatch at %0d ns: o_data = %h, expected 00", $time, rdata);
            errors++;
        end
        expect_int_n(1'b1);
        close_test("reset state");
    endtask

    task automatic test_vram_round_trip;
        set_addr(8'h21, 8'h08);
        bus_write(RS_PPUDATA, 8'hA5);
        bus_write(RS_PPUDATA, 8'h3C);
        set_addr(8'h21, 8'h08);
        // buffer still holds the last byte written
        expect_read(RS_PPUDATA, 8'h3C, "o_data on stale PPUDATA read");
        expect_read(RS_PPUDATA, 8'hA5, "o_data at 2108");
        expect_read(RS_PPUDATA, 8'h3C, "o_data at 2109");
        close_test("vram round trip");
    endtask

    task automatic test_increment_32;
        logic [7:0] discard;
        bus_write(RS_PPUCTRL, 8'h04);
        set_addr(8'h20, 8'h00);
        bus_write(RS_PPUDATA, 8'h5A);
        bus_write(RS_PPUDATA, 8'hC3);
        set_addr(8'h20, 8'h00);
        expect_read(RS_PPUDATA, 8'hC3, "o_data on stale PPUDATA read");
        expect_read(RS_PPUDATA, 8'h5A, "o_data at 2000");
        expect_read(RS_PPUDATA, 8'hC3, "o_data at 2020");
        bus_write(RS_PPUCTRL, 8'h00);
        // with unit stride, 2020 must hold the second byte
        set_addr(8'h20, 8'h20);
        // first read only primes the buffer
        bus_read(RS_PPUDATA, discard);
        expect_read(RS_PPUDATA, 8'hC3, "o_data at 2020 with unit stride");
        close_test("increment by 32");
    endtask

    task automatic test_palette_mirror;
        logic [23:0] exp_rgb;
        set_addr(8'h3F, 8'h10);
        bus_write(RS_PPUDATA, 8'h30);
        set_addr(8'h3F, 8'h00);
        // 3F10 lands on the backdrop entry, read without the buffer delay
        expect_read(RS_PPUDATA, 8'h30, "o_data at 3F00");
        exp_rgb = MASTER_RGB[6'h30];
        if ({video_red, video_green, video_blue} !== exp_rgb)
        begin
            $display("Mismatch at %0d ns: o_video_rgb = %h, expected %h",
                     $time, {video_red, video_green, video_blue}, exp_rgb);
            errors++;
        end
        close_test("palette mirroring");
    endtask

    task automatic test_oam;
        bus_write(RS_OAMADDR, 8'h10);
        bus_write(RS_OAMDATA, 8'h11);
        bus_write(RS_OAMDATA, 8'h22);
        bus_write(RS_OAMDATA, 8'h33);
        bus_write(RS_OAMADDR, 8'h11);
        expect_read(RS_OAMDATA, 8'h22, "o_data at OAM 11");
        bus_write(RS_OAMADDR, 8'h12);
        expect_read(RS_OAMDATA, 8'h33, "o_data at OAM 12");
        close_test("oam");
    endtask

    task automatic test_vblank_nmi;
        bus_write(RS_PPUCTRL, 8'h80);
        expect_int_n(1'b1);
        @(negedge clk);
        while (!(video_y == VBLANK_START_LINE && video_x == 9'd1))
            @(negedge clk);
        expect_int_n(1'b0);
        expect_read(RS_PPUSTATUS, 8'h80, "o_data on PPUSTATUS read");
        expect_int_n(1'b1);
        expect_read(RS_PPUSTATUS, 8'h00, "o_data on second PPUSTATUS read");
        bus_write(RS_PPUCTRL, 8'h00);
        close_test("vblank and nmi");
    endtask

    task automatic test_scroll_toggle;
        bus_write(RS_PPUSCROLL, 8'h7D);
        // leaves w set until the status read clears it
        expect_read(RS_PPUSTATUS, 8'h00, "o_data on PPUSTATUS read");
        set_addr(8'h23, 8'hC0);
        bus_write(RS_PPUDATA, 8'h9E);
        bus_write(RS_PPUDATA, 8'h4B);
        set_addr(8'h23, 8'hC0);
        expect_read(RS_PPUDATA, 8'h4B, "o_data on stale PPUDATA read");
        expect_read(RS_PPUDATA, 8'h9E, "o_data at 23C0");
        expect_read(RS_PPUDATA, 8'h4B, "o_data at 23C1");
        close_test("scroll toggle");
    endtask

    initial
    begin
        clk = 1'b0;
        reset_n = 1'b0;
        cs_n = 1'b1;
        rw = RW_READ;
        rs = RS_PPUCTRL;
        wdata = 8'h00;
        cycles = 0;
        errors = 0;
        errors_before = 0;
        tests_run = 0;
        tests_failed = 0;

        repeat (3) @(posedge clk);
        reset_n <= 1'b1;

        test_reset_state();
        test_vram_round_trip();
        test_increment_32();
        test_palette_mirror();
        test_oam();
        test_vblank_nmi();
        test_scroll_toggle();

        $display("%0d tests run, %0d with errors, %0d check errors in total",
                 tests_run, tests_failed, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire
